// File: hdl/ex_types_pkg.sv
/*
  Execute stage data types
  Word, double-word, register address and shift amount widths
*/

`default_nettype none

package ex_types_pkg;

  // Integer register width of RV32
  localparam int unsigned XLEN = 32;

  // Register file address, one extra bit selects the upper bank
  localparam int unsigned REG_ADDR_W = 6;

  // Enough bits to shift across one word
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  // Operand, result and target word
  typedef logic [XLEN-1:0] word_t;

  // Full product of two words
  typedef logic [2*XLEN-1:0] dword_t;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

// File: hdl/ex_ops_pkg.sv
/*
  Execute stage operation encodings
  ALU and multiplier opcodes, multiplier states, class helpers
*/

`default_nettype none

package ex_ops_pkg;

  // ALU opcodes, all 16 codes in use
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  typedef enum logic {
    MULT_IDLE   = 1'b0,
    MULT_FINISH = 1'b1
  } mult_state_e;

  // Compare class, result is a single flag
  function automatic logic alu_is_cmp(alu_op_e op);
    return op inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  endfunction

  // Upper-word products take two cycles
  function automatic logic mult_is_high(mult_op_e op);
    return op != MUL;
  endfunction

  function automatic logic mult_a_signed(mult_op_e op);
    return (op == MULH) || (op == MULHSU);
  endfunction

  function automatic logic mult_b_signed(mult_op_e op);
    return op == MULH;
  endfunction

endpackage

`default_nettype wire

// File: hdl/ex_alu.sv
/*
  Integer ALU
  Add/sub on one adder, logic, shifts, set-less-than and branch compare
*/

`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  var ex_ops_pkg::alu_op_e operator_i,
  input  var ex_types_pkg::word_t operand_a_i,
  input  var ex_types_pkg::word_t operand_b_i,
  output ex_types_pkg::word_t     result_o,
  output logic                    cmp_result_o
);

  ex_types_pkg::word_t  adder_b;
  ex_types_pkg::word_t  adder_sum;
  ex_types_pkg::shamt_t shamt;
  logic                 sub;
  logic                 lt_s;
  logic                 lt_u;
  logic                 eq;

  //////////////////////////////
  // Adder and shifter
  //////////////////////////////

  // Subtract as a + ~b + 1
  assign sub       = (operator_i == ex_ops_pkg::ALU_SUB);
  assign adder_b   = sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = operand_a_i + adder_b + ex_types_pkg::word_t'(sub);

  // Only the low bits of B count
  assign shamt = operand_b_i[$bits(ex_types_pkg::shamt_t)-1:0];

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u = operand_a_i < operand_b_i;
  assign eq   = operand_a_i == operand_b_i;

  always_comb begin
    case (operator_i)
      ex_ops_pkg::ALU_SLT,
      ex_ops_pkg::ALU_LT:   cmp_result_o = lt_s;
      ex_ops_pkg::ALU_SLTU,
      ex_ops_pkg::ALU_LTU:  cmp_result_o = lt_u;
      ex_ops_pkg::ALU_EQ:   cmp_result_o = eq;
      ex_ops_pkg::ALU_NE:   cmp_result_o = ~eq;
      ex_ops_pkg::ALU_GE:   cmp_result_o = ~lt_s;
      ex_ops_pkg::ALU_GEU:  cmp_result_o = ~lt_u;
      // Not a compare
      default:              cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    if (ex_ops_pkg::alu_is_cmp(operator_i)) begin
      // Flag zero-extended to a word
      result_o = ex_types_pkg::word_t'(cmp_result_o);
    end else begin
      case (operator_i)
        ex_ops_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
        ex_ops_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
        ex_ops_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
        ex_ops_pkg::ALU_SLL: result_o = operand_a_i << shamt;
        ex_ops_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
        ex_ops_pkg::ALU_SRA: result_o = $signed(operand_a_i) >>> shamt;
        // Add and subtract share the adder
        default:             result_o = adder_sum;
      endcase
    end
  end

  // Known operands in flight need a known opcode
  always_comb begin
    if (!$isunknown({operand_a_i, operand_b_i})) begin
      assert (!$isunknown(operator_i))
        else $error("ALU operator is unknown with valid operands");
    end
  end

endmodule

`default_nettype wire

// File: hdl/ex_mult.sv
/*
  Integer multiplier
  MUL in one cycle, MULH/MULHSU/MULHU in two via a half-width split of B
*/

`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable_i,
  input  var ex_ops_pkg::mult_op_e operator_i,
  input  var ex_types_pkg::word_t  op_a_i,
  input  var ex_types_pkg::word_t  op_b_i,
  input  wire                      ex_ready_i,
  output ex_types_pkg::word_t      result_o,
  output logic                     ready_o,
  output logic                     multicycle_o
);

  localparam int unsigned XLEN   = ex_types_pkg::XLEN;
  localparam int unsigned HALF_W = XLEN / 2;

  ex_ops_pkg::mult_state_e state_q;
  ex_ops_pkg::mult_state_e state_d;

  ex_types_pkg::dword_t a_ext;
  ex_types_pkg::dword_t b_lo_ext;
  ex_types_pkg::dword_t b_hi_ext;
  ex_types_pkg::dword_t partial_lo;
  ex_types_pkg::dword_t partial_hi;
  ex_types_pkg::dword_t partial_q;
  ex_types_pkg::dword_t product;
  ex_types_pkg::word_t  mul_lo;
  logic                 high_op;
  logic                 a_neg;
  logic                 b_neg;
  logic                 start_high;

  //////////////////////////////
  // Operand extension
  //////////////////////////////

  assign high_op = ex_ops_pkg::mult_is_high(operator_i);
  assign a_neg   = ex_ops_pkg::mult_a_signed(operator_i) & op_a_i[XLEN-1];
  assign b_neg   = ex_ops_pkg::mult_b_signed(operator_i) & op_b_i[XLEN-1];

  // 64-bit wraparound gives the right two's complement product
  assign a_ext    = {{XLEN{a_neg}}, op_a_i};
  // Low half of B is always unsigned
  assign b_lo_ext = {{(2*XLEN-HALF_W){1'b0}}, op_b_i[HALF_W-1:0]};
  // High half carries the sign of B
  assign b_hi_ext = {{(2*XLEN-HALF_W){b_neg}}, op_b_i[XLEN-1:HALF_W]};

  // Phase 1 and phase 2 partial products
  assign partial_lo = a_ext * b_lo_ext;
  assign partial_hi = (a_ext * b_hi_ext) << HALF_W;
  assign product    = partial_q + partial_hi;

  // Plain MUL, only the low word is needed
  assign mul_lo = op_a_i * op_b_i;

  assign result_o = high_op ? product[2*XLEN-1:XLEN] : mul_lo;

  //////////////////////////////
  // FSM
  //////////////////////////////

  assign start_high = (state_q == ex_ops_pkg::MULT_IDLE) && enable_i && high_op;

  always_comb begin
    state_d = state_q;
    ready_o = 1'b1;
    case (state_q)
      ex_ops_pkg::MULT_IDLE: begin
        // Stall one cycle while the low partial is stored
        if (start_high) begin
          ready_o = 1'b0;
          state_d = ex_ops_pkg::MULT_FINISH;
        end
      end
      ex_ops_pkg::MULT_FINISH: begin
        // Result held until the stage moves on
        if (ex_ready_i) begin
          state_d = ex_ops_pkg::MULT_IDLE;
        end
      end
      default: state_d = ex_ops_pkg::MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_ops_pkg::MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Low partial product, loaded on the first cycle only
  always_ff @(posedge clk) begin
    if (start_high) begin
      partial_q <= partial_lo;
    end
  end

  assign multicycle_o = (state_q == ex_ops_pkg::MULT_FINISH);

  // Decode holds the high multiply for the whole second phase
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_ops_pkg::MULT_FINISH)
      |-> enable_i && ex_ops_pkg::mult_is_high(operator_i)
          && $stable(operator_i) && $stable(op_a_i) && $stable(op_b_i))
    else $error("Multiplier inputs changed while in FINISH");

endmodule

`default_nettype wire

// File: hdl/ex_ctrl.sv
/*
  Execute stage control
  Forwarding write port select, EX/WB load port register, ready/valid
*/

`timescale 1ns/1ps
`default_nettype none

module ex_ctrl (
  input  wire                         clk,
  input  wire                         rst_n,

  // Unit enables and result sources
  input  wire                         alu_en_i,
  input  wire                         mult_en_i,
  input  wire                         csr_access_i,
  input  wire                         lsu_en_i,
  input  var ex_types_pkg::word_t     alu_result_i,
  input  var ex_types_pkg::word_t     mult_result_i,
  input  var ex_types_pkg::word_t     csr_rdata_i,
  input  wire                         mult_ready_i,

  // Write ports from decode
  input  wire                         regfile_alu_we_i,
  input  var ex_types_pkg::reg_addr_t regfile_alu_waddr_i,
  input  wire                         regfile_we_i,
  input  var ex_types_pkg::reg_addr_t regfile_waddr_i,

  // Load/store unit and write-back handshake
  input  var ex_types_pkg::word_t     lsu_rdata_i,
  input  wire                         lsu_ready_ex_i,
  input  wire                         lsu_err_i,
  input  wire                         wb_ready_i,
  input  wire                         branch_in_ex_i,

  output logic                        regfile_alu_we_fw_o,
  output ex_types_pkg::reg_addr_t     regfile_alu_waddr_fw_o,
  output ex_types_pkg::word_t         regfile_alu_wdata_fw_o,
  output logic                        regfile_we_wb_o,
  output ex_types_pkg::reg_addr_t     regfile_waddr_wb_o,
  output ex_types_pkg::word_t         regfile_wdata_wb_o,
  output logic                        ex_ready_o,
  output logic                        ex_valid_o
);

  logic                    we_wb_q;
  ex_types_pkg::reg_addr_t waddr_wb_q;
  logic                    lsu_write;
  logic                    units_ready;

  //////////////////////////////
  // Forwarding write port
  //////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // A faulting access never reaches the register file
  assign lsu_write = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_wb_q    <= 1'b0;
      waddr_wb_q <= '0;
    end else if (ex_valid_o) begin
      // wb_ready_i is implied by valid
      we_wb_q <= lsu_write;
      if (lsu_write) begin
        waddr_wb_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble, flush the old write out
      we_wb_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = we_wb_q;
  assign regfile_waddr_wb_o = waddr_wb_q;
  // Load data arrives with the write-back cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here and never need write-back
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid goes right and does not look at ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Decode issues to one result source at a time
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i}))
    else $error("More than one of ALU, multiplier and CSR enabled");

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
/*
  Execute stage top level
  Connects ALU and multiplier to the stage control
*/

`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  wire                         clk,
  input  wire                         rst_n,

  // ALU operands from decode
  input  var ex_ops_pkg::alu_op_e     alu_operator_i,
  input  var ex_types_pkg::word_t     alu_operand_a_i,
  input  var ex_types_pkg::word_t     alu_operand_b_i,
  input  var ex_types_pkg::word_t     alu_operand_c_i,
  input  wire                         alu_en_i,

  // Multiplier operands from decode
  input  var ex_ops_pkg::mult_op_e    mult_operator_i,
  input  var ex_types_pkg::word_t     mult_operand_a_i,
  input  var ex_types_pkg::word_t     mult_operand_b_i,
  input  wire                         mult_en_i,
  output logic                        mult_multicycle_o,

  input  wire                         lsu_en_i,
  input  var ex_types_pkg::word_t     lsu_rdata_i,

  input  wire                         branch_in_ex_i,
  input  var ex_types_pkg::reg_addr_t regfile_alu_waddr_i,
  input  wire                         regfile_alu_we_i,
  input  wire                         regfile_we_i,
  input  var ex_types_pkg::reg_addr_t regfile_waddr_i,

  input  wire                         csr_access_i,
  input  var ex_types_pkg::word_t     csr_rdata_i,

  // Load write port to write-back
  output ex_types_pkg::reg_addr_t     regfile_waddr_wb_o,
  output logic                        regfile_we_wb_o,
  output ex_types_pkg::word_t         regfile_wdata_wb_o,

  // Forwarding port back to decode
  output ex_types_pkg::reg_addr_t     regfile_alu_waddr_fw_o,
  output logic                        regfile_alu_we_fw_o,
  output ex_types_pkg::word_t         regfile_alu_wdata_fw_o,

  // Branch outcome to fetch
  output ex_types_pkg::word_t         jump_target_o,
  output logic                        branch_decision_o,

  input  wire                         lsu_ready_ex_i,
  input  wire                         lsu_err_i,
  output logic                        ex_ready_o,
  output logic                        ex_valid_o,
  input  wire                         wb_ready_i
);

  ex_types_pkg::word_t alu_result;
  ex_types_pkg::word_t mult_result;
  logic                mult_ready;

  // Target computed in decode, just passed on
  assign jump_target_o = alu_operand_c_i;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////
  // Control
  //////////////////////////////

  ex_ctrl ctrl_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: bench/ex_clk_gen.sv
/*
  Testbench clock and reset
  4 ns clock, reset held low for the first two cycles
*/

`timescale 1ns/1ps
`default_nettype none

module ex_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Released on the second rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/ex_stage_tb.sv
/*
  Execute stage testbench
  Random ALU, branch, multiply, CSR, EX/WB and back-pressure checks
*/

`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

  logic clk;
  logic rst_n;

  // DUT inputs
  ex_ops_pkg::alu_op_e     alu_op;
  ex_types_pkg::word_t     op_a;
  ex_types_pkg::word_t     op_b;
  ex_types_pkg::word_t     op_c;
  logic                    alu_en;
  ex_ops_pkg::mult_op_e    mult_op;
  ex_types_pkg::word_t     mul_a;
  ex_types_pkg::word_t     mul_b;
  logic                    mult_en;
  logic                    lsu_en;
  ex_types_pkg::word_t     lsu_rdata;
  logic                    branch_in_ex;
  ex_types_pkg::reg_addr_t alu_waddr;
  logic                    alu_we;
  logic                    we;
  ex_types_pkg::reg_addr_t waddr;
  logic                    csr_access;
  ex_types_pkg::word_t     csr_rdata;
  logic                    lsu_ready;
  logic                    lsu_err;
  logic                    wb_ready;

  // DUT outputs
  logic                    multicycle;
  ex_types_pkg::reg_addr_t waddr_wb;
  logic                    we_wb;
  ex_types_pkg::word_t     wdata_wb;
  ex_types_pkg::reg_addr_t alu_waddr_fw;
  logic                    alu_we_fw;
  ex_types_pkg::word_t     alu_wdata_fw;
  ex_types_pkg::word_t     jump_target;
  logic                    branch_decision;
  logic                    ex_ready;
  logic                    ex_valid;

  // Expectations set by the stimulus, used by the comparing process
  string                   test_name;
  logic                    chk_hs;
  logic                    chk_data;
  logic                    chk_cmp;
  logic                    exp_ready;
  logic                    exp_valid;
  logic [32:0]             expv;
  integer                  seed;
  logic [31:0]             r;
  int                      stalls;
  ex_types_pkg::reg_addr_t last_addr;
  logic                    exp_we;

  ex_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage UUT (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (alu_op),
    .alu_operand_a_i        (op_a),
    .alu_operand_b_i        (op_b),
    .alu_operand_c_i        (op_c),
    .alu_en_i               (alu_en),
    .mult_operator_i        (mult_op),
    .mult_operand_a_i       (mul_a),
    .mult_operand_b_i       (mul_b),
    .mult_en_i              (mult_en),
    .mult_multicycle_o      (multicycle),
    .lsu_en_i               (lsu_en),
    .lsu_rdata_i            (lsu_rdata),
    .branch_in_ex_i         (branch_in_ex),
    .regfile_alu_waddr_i    (alu_waddr),
    .regfile_alu_we_i       (alu_we),
    .regfile_we_i           (we),
    .regfile_waddr_i        (waddr),
    .csr_access_i           (csr_access),
    .csr_rdata_i            (csr_rdata),
    .regfile_waddr_wb_o     (waddr_wb),
    .regfile_we_wb_o        (we_wb),
    .regfile_wdata_wb_o     (wdata_wb),
    .regfile_alu_waddr_fw_o (alu_waddr_fw),
    .regfile_alu_we_fw_o    (alu_we_fw),
    .regfile_alu_wdata_fw_o (alu_wdata_fw),
    .jump_target_o          (jump_target),
    .branch_decision_o      (branch_decision),
    .lsu_ready_ex_i         (lsu_ready),
    .lsu_err_i              (lsu_err),
    .ex_ready_o             (ex_ready),
    .ex_valid_o             (ex_valid),
    .wb_ready_i             (wb_ready)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Returns {comparison flag, forwarding data}
  function automatic logic [32:0] ref_result(
    input ex_ops_pkg::alu_op_e  op,
    input ex_types_pkg::word_t  a,
    input ex_types_pkg::word_t  b,
    input logic                 m_en,
    input ex_ops_pkg::mult_op_e m_op,
    input ex_types_pkg::word_t  ma,
    input ex_types_pkg::word_t  mb,
    input logic                 csr,
    input ex_types_pkg::word_t  csr_d
  );
    ex_types_pkg::dword_t pa;
    ex_types_pkg::dword_t pb;
    ex_types_pkg::dword_t prod;
    ex_types_pkg::word_t  res;
    logic                 cmp;
    case (op)
      ex_ops_pkg::ALU_EQ:   cmp = (a == b);
      ex_ops_pkg::ALU_NE:   cmp = (a != b);
      ex_ops_pkg::ALU_SLT,
      ex_ops_pkg::ALU_LT:   cmp = ($signed(a) < $signed(b));
      ex_ops_pkg::ALU_GE:   cmp = ($signed(a) >= $signed(b));
      ex_ops_pkg::ALU_SLTU,
      ex_ops_pkg::ALU_LTU:  cmp = (a < b);
      ex_ops_pkg::ALU_GEU:  cmp = (a >= b);
      default:              cmp = 1'b0;
    endcase
    case (op)
      ex_ops_pkg::ALU_ADD: res = a + b;
      ex_ops_pkg::ALU_SUB: res = a - b;
      ex_ops_pkg::ALU_AND: res = a & b;
      ex_ops_pkg::ALU_OR:  res = a | b;
      ex_ops_pkg::ALU_XOR: res = a ^ b;
      ex_ops_pkg::ALU_SLL: res = a << b[4:0];
      ex_ops_pkg::ALU_SRL: res = a >> b[4:0];
      ex_ops_pkg::ALU_SRA: res = $signed(a) >>> b[4:0];
      default:             res = {31'b0, cmp};
    endcase
    // Full 64-bit product with per-operation operand signedness
    pa = (m_op == ex_ops_pkg::MULH || m_op == ex_ops_pkg::MULHSU) ?
         {{32{ma[31]}}, ma} : {32'b0, ma};
    pb = (m_op == ex_ops_pkg::MULH) ? {{32{mb[31]}}, mb} : {32'b0, mb};
    prod = pa * pb;
    if (csr) begin
      res = csr_d;
    end else if (m_en) begin
      res = (m_op == ex_ops_pkg::MUL) ? prod[31:0] : prod[63:32];
    end
    return {cmp, res};
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(
    input string               name,
    input ex_types_pkg::word_t expected,
    input ex_types_pkg::word_t actual
  );
    if (actual !== expected) begin
      abort($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_ops();
    alu_en       = 1'b0;
    mult_en      = 1'b0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    branch_in_ex = 1'b0;
    alu_we       = 1'b0;
    we           = 1'b0;
    lsu_err      = 1'b0;
    chk_hs       = 1'b0;
    chk_data     = 1'b0;
    chk_cmp      = 1'b0;
  endtask

  task automatic expect_hs(input logic rdy, input logic vld);
    exp_ready = rdy;
    exp_valid = vld;
    chk_hs    = 1'b1;
  endtask

  // Counts stalled cycles until ex_ready_o is high at the falling edge
  task automatic wait_ready(output int n);
    n = 0;
    @(negedge clk);
    while (!ex_ready && n < 20) begin
      n++;
      next_cycle();
      // Held operation finishes after a stall
      chk_data = 1'b1;
      expect_hs(1'b1, 1'b1);
      @(negedge clk);
    end
    if (!ex_ready) begin
      abort($sformatf("timeout waiting for ex_ready_o in %s", test_name));
    end
  endtask

  //////////////////////////////
  // Comparing process
  //////////////////////////////

  always @(negedge clk) begin
    expv = ref_result(alu_op, op_a, op_b, mult_en, mult_op, mul_a, mul_b,
                      csr_access, csr_rdata);
    if (chk_hs) begin
      check_val({test_name, " ready"}, 32'(exp_ready), 32'(ex_ready));
      check_val({test_name, " valid"}, 32'(exp_valid), 32'(ex_valid));
    end
    if (chk_data) begin
      check_val({test_name, " data"}, expv[31:0], alu_wdata_fw);
    end
    if (chk_cmp) begin
      check_val({test_name, " branch"}, 32'(expv[32]), 32'(branch_decision));
      check_val({test_name, " target"}, op_c, jump_target);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    seed      = 13;
    alu_op    = ex_ops_pkg::ALU_ADD;
    op_a      = '0;
    op_b      = '0;
    op_c      = '0;
    mult_op   = ex_ops_pkg::MUL;
    mul_a     = '0;
    mul_b     = '0;
    lsu_rdata = '0;
    alu_waddr = '0;
    waddr     = '0;
    csr_rdata = '0;
    lsu_ready = 1'b1;
    wb_ready  = 1'b1;
    exp_ready = 1'b1;
    exp_valid = 1'b0;
    last_addr = '0;
    exp_we    = 1'b0;
    test_name = "reset";
    clear_ops();

    for (int n = 0; n < 20 && !rst_n; n++) begin
      @(posedge clk);
    end
    if (!rst_n) begin
      abort("reset was never released");
    end
    next_cycle();
    @(negedge clk);
    check_val("reset we_wb", 0, 32'(we_wb));
    check_val("reset waddr_wb", 0, 32'(waddr_wb));
    check_val("reset multicycle", 0, 32'(multicycle));
    next_cycle();

    // Random ALU operations, add through set-less-than
    test_name = "alu";
    for (int i = 0; i < 40; i++) begin
      r         = $random(seed);
      alu_op    = ex_ops_pkg::alu_op_e'(r[3:0] % 4'(ex_ops_pkg::ALU_EQ));
      op_a      = $random(seed);
      op_b      = $random(seed);
      alu_en    = 1'b1;
      alu_we    = 1'b1;
      alu_waddr = r[9:4];
      chk_data  = 1'b1;
      expect_hs(1'b1, 1'b1);
      wait_ready(stalls);
      check_val("alu stalls", 0, stalls);
      next_cycle();
    end
    clear_ops();

    // Six branch compares, the last round under write-back stall
    test_name = "branch";
    for (int i = 0; i < 36; i++) begin
      r            = $random(seed);
      alu_op       = ex_ops_pkg::alu_op_e'(4'(ex_ops_pkg::ALU_EQ) + 4'(i % 6));
      op_a         = $random(seed);
      op_b         = (r[1:0] == 2'b00) ? op_a : $random(seed);
      op_c         = $random(seed);
      alu_en       = 1'b1;
      branch_in_ex = 1'b1;
      wb_ready     = (i < 30);
      chk_cmp      = 1'b1;
      expect_hs(1'b1, wb_ready);
      wait_ready(stalls);
      next_cycle();
    end
    wb_ready = 1'b1;
    clear_ops();

    // MUL completes at once, the high variants stall one cycle
    test_name = "mult";
    for (int i = 0; i < 32; i++) begin
      mult_op  = ex_ops_pkg::mult_op_e'(2'(i));
      mul_a    = $random(seed);
      mul_b    = $random(seed);
      mult_en  = 1'b1;
      chk_data = (mult_op == ex_ops_pkg::MUL);
      expect_hs(chk_data, chk_data);
      wait_ready(stalls);
      check_val("mult stalls", (mult_op == ex_ops_pkg::MUL) ? 0 : 1, stalls);
      check_val("mult multicycle", (mult_op == ex_ops_pkg::MUL) ? 0 : 1, 32'(multicycle));
      next_cycle();
    end
    clear_ops();

    // CSR read data wins the forwarding port
    test_name = "csr";
    for (int i = 0; i < 8; i++) begin
      r          = $random(seed);
      csr_access = 1'b1;
      csr_rdata  = $random(seed);
      alu_we     = r[0];
      alu_waddr  = r[6:1];
      chk_data   = 1'b1;
      expect_hs(1'b1, 1'b1);
      wait_ready(stalls);
      check_val("csr stalls", 0, stalls);
      check_val("csr we_fw", 32'(alu_we), 32'(alu_we_fw));
      check_val("csr waddr_fw", 32'(alu_waddr), 32'(alu_waddr_fw));
      next_cycle();
    end
    clear_ops();

    // Load write port, a faulting access writes nothing
    test_name = "exwb";
    for (int i = 0; i < 6; i++) begin
      r       = $random(seed);
      lsu_en  = 1'b1;
      we      = 1'b1;
      waddr   = r[5:0];
      lsu_err = (i % 3 == 2);
      exp_we  = !lsu_err;
      if (exp_we) begin
        last_addr = waddr;
      end
      expect_hs(1'b1, 1'b1);
      wait_ready(stalls);
      next_cycle();
      clear_ops();
      lsu_rdata = $random(seed);
      expect_hs(1'b1, 1'b0);
      @(negedge clk);
      check_val("exwb we_wb", 32'(exp_we), 32'(we_wb));
      check_val("exwb waddr_wb", 32'(last_addr), 32'(waddr_wb));
      check_val("exwb wdata_wb", lsu_rdata, wdata_wb);
      // Idle cycle with write-back ready flushes the write
      next_cycle();
      @(negedge clk);
      check_val("exwb idle we_wb", 0, 32'(we_wb));
      next_cycle();
    end
    clear_ops();

    // Stall from write-back, then from the load/store unit
    test_name = "stall";
    for (int k = 0; k < 2; k++) begin
      r         = $random(seed);
      lsu_en    = 1'b1;
      we        = 1'b1;
      waddr     = r[5:0];
      last_addr = waddr;
      expect_hs(1'b1, 1'b1);
      wait_ready(stalls);
      next_cycle();
      clear_ops();
      alu_op   = ex_ops_pkg::ALU_ADD;
      op_a     = $random(seed);
      op_b     = $random(seed);
      alu_en   = 1'b1;
      we       = 1'b1;
      waddr    = r[11:6];
      chk_data = 1'b1;
      if (k == 0) begin
        wb_ready = 1'b0;
      end else begin
        lsu_ready = 1'b0;
      end
      expect_hs(1'b0, 1'b0);
      for (int j = 0; j < 3; j++) begin
        @(negedge clk);
        // Bubble with write-back ready still clears the pending write
        check_val("stall we_wb", (j == 0 || k == 0) ? 1 : 0, 32'(we_wb));
        check_val("stall waddr_wb", 32'(last_addr), 32'(waddr_wb));
        next_cycle();
      end
      wb_ready  = 1'b1;
      lsu_ready = 1'b1;
      expect_hs(1'b1, 1'b1);
      wait_ready(stalls);
      check_val("stall release", 0, stalls);
      last_addr = waddr;
      next_cycle();
      clear_ops();
      expect_hs(1'b1, 1'b0);
      @(negedge clk);
      check_val("stall done we_wb", 1, 32'(we_wb));
      check_val("stall done waddr_wb", 32'(last_addr), 32'(waddr_wb));
      next_cycle();
    end
    clear_ops();
    next_cycle();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/ex_types_pkg.sv
hdl/ex_ops_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_ctrl.sv
hdl/ex_stage.sv
bench/ex_clk_gen.sv
bench/ex_stage_tb.sv

// File: Makefile
# Verilator flow for the execute stage

TOP = ex_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module ex_stage

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
